// File: address_generation.sv
`timescale 1ns/1ps
`include "ag_consts.svh"

module address_generation (
   input  logic             clk,
   input  logic             rst_n,

   ag_rf_if.stage           rf,

   // From decode
   input  logic             v,
   input  ag_pkg::ag_op_e   op,
   input  ag_pkg::gpr_id_t  sr1,
   input  ag_pkg::gpr_id_t  sr2,
   input  ag_pkg::gpr_id_t  sib_i,
   input  logic [1:0]       sib_s,
   input  logic             sib_en,
   input  logic             disp_en,
   input  logic             base_en,
   input  ag_pkg::seg_id_t  seg1,
   input  ag_pkg::size_e    data_size,
   input  logic [31:0]      disp32,
   input  logic [31:0]      imm32,
   input  logic [31:0]      eip,
   input  logic [3:0]       exc_code,

   // In-flight destinations of later stages
   input  logic [2:0]       ex_drid,
   input  logic             v_ex_ld_gpr,
   input  logic             v_ex_ld_seg,
   input  logic [2:0]       me_drid,
   input  logic             v_me_ld_gpr,
   input  logic             v_me_ld_seg,

   output logic             stall,

   // Pipeline latch toward EX
   output logic             out_v,
   output ag_pkg::ag_op_e   out_op,
   output logic [31:0]      out_a,
   output logic [31:0]      out_b,
   output logic [31:0]      out_neip,
   output logic [31:0]      out_mem_rd_addr,
   output logic [31:0]      out_mem_wr_addr,
   output logic             out_mem_rd,
   output logic             out_mem_wr,
   output ag_pkg::gpr_id_t  out_drid,
   output logic             out_ld_gpr,
   output logic             out_seg_exc
);
   import ag_pkg::*;

   ag_dep_if dep ();

   logic        is_alu, is_load, is_store, is_push, is_int;
   logic [31:0] base_part, disp_part, idx_part, offset, seg_addr;
   logic [31:0] new_sp, stack_addr, int_addr, neip, b_val;
   logic        seg_exc, mem_rd, mem_wr, ld_gpr, accept;
   gpr_id_t     drid;

   assign is_alu   = (op == op_alu_rr) || (op == op_alu_ri);
   assign is_load  = (op == op_load);
   assign is_store = (op == op_store);
   assign is_push  = (op == op_push);
   assign is_int   = (op == op_int);

   assign rf.gpr_rd_a   = sr1;
   assign rf.gpr_rd_b   = sr2;
   assign rf.gpr_rd_idx = sib_i;
   assign rf.seg_rd_a   = seg1;
   assign rf.seg_rd_b   = seg_id_t'(`AG_SS_ID);

   // Effective offset = base + disp + (index << scale)
   assign base_part = base_en ? rf.gpr_data_a : 32'h0;
   assign disp_part = disp_en ? disp32 : 32'h0;
   assign idx_part  = sib_en ? (rf.gpr_data_idx << sib_s) : 32'h0;
   assign offset    = base_part + disp_part + idx_part;
   assign seg_addr  = {rf.seg_data_a, 16'h0000} + offset;

   // Push predecrements ESP by the operand size
   assign new_sp     = rf.gpr_data_b - ((data_size == sz16) ? 32'd2 : 32'd4);
   assign stack_addr = {rf.seg_data_b, 16'h0000} + new_sp;

   assign int_addr = `AG_IDTR_BASE + {25'h0, exc_code, 3'b000};
   assign neip     = (op == op_jmp_rel) ? (eip + disp32) : eip;
   assign b_val    = (op == op_alu_ri) ? imm32 : rf.gpr_data_b;

   // A segment fault kills the memory access
   assign mem_rd = (is_load || is_int) && !seg_exc;
   assign mem_wr = (is_store || is_push) && !seg_exc;
   assign ld_gpr = is_alu || is_load || is_push;
   assign drid   = is_push ? sr2 : sr1;

   assign dep.src1     = sr1;
   assign dep.need1    = base_en || is_alu || is_push;
   assign dep.src2     = sr2;
   assign dep.need2    = (op == op_alu_rr) || is_store || is_push;
   assign dep.src_idx  = sib_i;
   assign dep.need_idx = sib_en;
   assign dep.src_seg  = is_push ? seg_id_t'(`AG_SS_ID) : seg1;
   assign dep.need_seg = is_load || is_store || is_push;

   assign dep.lat_drid   = out_drid;
   assign dep.lat_ld_gpr = out_v && out_ld_gpr;
   // No opcode here writes a segment register
   assign dep.lat_ld_seg = 1'b0;

   reg_dependency_check u_reg_dependency_check (
      .v           (v),
      .dep         (dep),
      .ex_drid     (ex_drid),
      .v_ex_ld_gpr (v_ex_ld_gpr),
      .v_ex_ld_seg (v_ex_ld_seg),
      .me_drid     (me_drid),
      .v_me_ld_gpr (v_me_ld_gpr),
      .v_me_ld_seg (v_me_ld_seg),
      .stall       (stall)
   );

   segment_limit_check u_seg_limit_check (
      .v         (v),
      .op        (op),
      .seg1      (seg1),
      .data_size (data_size),
      .offset    (offset),
      .exc       (seg_exc)
   );

   assign accept = v && !stall;

   // Control bits, a stall inserts a bubble
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_v       <= 1'b0;
         out_ld_gpr  <= 1'b0;
         out_mem_rd  <= 1'b0;
         out_mem_wr  <= 1'b0;
         out_seg_exc <= 1'b0;
      end else begin
         out_v       <= accept;
         out_ld_gpr  <= accept && ld_gpr;
         out_mem_rd  <= accept && mem_rd;
         out_mem_wr  <= accept && mem_wr;
         out_seg_exc <= accept && seg_exc;
      end
   end

   // Payload, only meaningful when out_v is set
   always_ff @(posedge clk) begin
      out_op          <= op;
      out_a           <= rf.gpr_data_a;
      out_b           <= b_val;
      out_neip        <= neip;
      out_mem_rd_addr <= is_int ? int_addr : seg_addr;
      out_mem_wr_addr <= is_push ? stack_addr : seg_addr;
      out_drid        <= drid;
   end

endmodule

// File: ag_consts.svh
`ifndef AG_CONSTS_SVH
`define AG_CONSTS_SVH

// Register file sizes
`define AG_NUM_GPR 8
`define AG_NUM_SEG 6

// Stack segment selector slot
`define AG_SS_ID 2

// Interrupt descriptor table base, entries are 8 bytes apart
`define AG_IDTR_BASE 32'h0000_0800

// Offset limits per segment
// ES, CS, SS, DS, FS, GS
`define AG_SEG_LIMIT0 32'h0000_FFFF
`define AG_SEG_LIMIT1 32'h0000_7FFF
`define AG_SEG_LIMIT2 32'h0000_3FFF
`define AG_SEG_LIMIT3 32'h0001_FFFF
`define AG_SEG_LIMIT4 32'h0000_0FFF
`define AG_SEG_LIMIT5 32'h0000_01FF

`endif

// File: ag_dep_if.sv
`timescale 1ns/1ps

interface ag_dep_if;
   import ag_pkg::*;

   // Sources the current instruction reads
   gpr_id_t    src1;
   gpr_id_t    src2;
   gpr_id_t    src_idx;
   seg_id_t    src_seg;
   logic       need1;
   logic       need2;
   logic       need_idx;
   logic       need_seg;

   // Destination held in the stage's own output latch
   logic [2:0] lat_drid;
   logic       lat_ld_gpr;
   logic       lat_ld_seg;

   modport stage (output src1, src2, src_idx, src_seg, need1, need2, need_idx, need_seg,
                  output lat_drid, lat_ld_gpr, lat_ld_seg);

   modport check (input src1, src2, src_idx, src_seg, need1, need2, need_idx, need_seg,
                  input lat_drid, lat_ld_gpr, lat_ld_seg);

endinterface

// File: ag_pkg.sv
package ag_pkg;

   // Opcodes the stage understands in place of the control store
   typedef enum logic [2:0] {
      op_alu_rr  = 3'd0,
      op_alu_ri  = 3'd1,
      op_load    = 3'd2,
      op_store   = 3'd3,
      op_push    = 3'd4,
      op_jmp_rel = 3'd5,
      op_int     = 3'd6
   } ag_op_e;

   // Operand size, same encoding as decode's DATA_SIZE
   typedef enum logic [1:0] {
      sz8  = 2'd0,
      sz16 = 2'd1,
      sz32 = 2'd2
   } size_e;

   // General register number, EAX..EDI
   typedef logic [2:0] gpr_id_t;

   // Segment register number, only 0 to 5 exist
   typedef logic [2:0] seg_id_t;

endpackage

// File: ag_rf_if.sv
`timescale 1ns/1ps

interface ag_rf_if;
   import ag_pkg::*;

   // Read IDs from the stage
   gpr_id_t     gpr_rd_a;
   gpr_id_t     gpr_rd_b;
   gpr_id_t     gpr_rd_idx;
   seg_id_t     seg_rd_a;
   seg_id_t     seg_rd_b;

   // Read data back from the register file
   logic [31:0] gpr_data_a;
   logic [31:0] gpr_data_b;
   logic [31:0] gpr_data_idx;
   logic [15:0] seg_data_a;
   logic [15:0] seg_data_b;

   modport stage (output gpr_rd_a, gpr_rd_b, gpr_rd_idx, seg_rd_a, seg_rd_b,
                  input  gpr_data_a, gpr_data_b, gpr_data_idx, seg_data_a, seg_data_b);

   modport regs (input  gpr_rd_a, gpr_rd_b, gpr_rd_idx, seg_rd_a, seg_rd_b,
                 output gpr_data_a, gpr_data_b, gpr_data_idx, seg_data_a, seg_data_b);

endinterface

// File: ag_top.sv
`timescale 1ns/1ps

module ag_top (
   input  logic             clk,
   input  logic             rst_n,

   input  logic             v,
   input  ag_pkg::ag_op_e   op,
   input  ag_pkg::gpr_id_t  sr1,
   input  ag_pkg::gpr_id_t  sr2,
   input  ag_pkg::gpr_id_t  sib_i,
   input  logic [1:0]       sib_s,
   input  logic             sib_en,
   input  logic             disp_en,
   input  logic             base_en,
   input  ag_pkg::seg_id_t  seg1,
   input  ag_pkg::size_e    data_size,
   input  logic [31:0]      disp32,
   input  logic [31:0]      imm32,
   input  logic [31:0]      eip,
   input  logic [3:0]       exc_code,

   input  logic             wb_gpr_we,
   input  ag_pkg::gpr_id_t  wb_gpr_id,
   input  logic [31:0]      wb_gpr_data,
   input  logic             wb_seg_we,
   input  ag_pkg::seg_id_t  wb_seg_id,
   input  logic [15:0]      wb_seg_data,

   input  logic [2:0]       ex_drid,
   input  logic             v_ex_ld_gpr,
   input  logic             v_ex_ld_seg,
   input  logic [2:0]       me_drid,
   input  logic             v_me_ld_gpr,
   input  logic             v_me_ld_seg,

   output logic             stall,
   output logic             out_v,
   output ag_pkg::ag_op_e   out_op,
   output logic [31:0]      out_a,
   output logic [31:0]      out_b,
   output logic [31:0]      out_neip,
   output logic [31:0]      out_mem_rd_addr,
   output logic [31:0]      out_mem_wr_addr,
   output logic             out_mem_rd,
   output logic             out_mem_wr,
   output ag_pkg::gpr_id_t  out_drid,
   output logic             out_ld_gpr,
   output logic             out_seg_exc
);

   ag_rf_if rf_bus ();

   register_file u_register_file (
      .clk         (clk),
      .rst_n       (rst_n),
      .rf          (rf_bus),
      .wb_gpr_we   (wb_gpr_we),
      .wb_gpr_id   (wb_gpr_id),
      .wb_gpr_data (wb_gpr_data),
      .wb_seg_we   (wb_seg_we),
      .wb_seg_id   (wb_seg_id),
      .wb_seg_data (wb_seg_data)
   );

   address_generation u_address_generation (
      .clk             (clk),
      .rst_n           (rst_n),
      .rf              (rf_bus),
      .v               (v),
      .op              (op),
      .sr1             (sr1),
      .sr2             (sr2),
      .sib_i           (sib_i),
      .sib_s           (sib_s),
      .sib_en          (sib_en),
      .disp_en         (disp_en),
      .base_en         (base_en),
      .seg1            (seg1),
      .data_size       (data_size),
      .disp32          (disp32),
      .imm32           (imm32),
      .eip             (eip),
      .exc_code        (exc_code),
      .ex_drid         (ex_drid),
      .v_ex_ld_gpr     (v_ex_ld_gpr),
      .v_ex_ld_seg     (v_ex_ld_seg),
      .me_drid         (me_drid),
      .v_me_ld_gpr     (v_me_ld_gpr),
      .v_me_ld_seg     (v_me_ld_seg),
      .stall           (stall),
      .out_v           (out_v),
      .out_op          (out_op),
      .out_a           (out_a),
      .out_b           (out_b),
      .out_neip        (out_neip),
      .out_mem_rd_addr (out_mem_rd_addr),
      .out_mem_wr_addr (out_mem_wr_addr),
      .out_mem_rd      (out_mem_rd),
      .out_mem_wr      (out_mem_wr),
      .out_drid        (out_drid),
      .out_ld_gpr      (out_ld_gpr),
      .out_seg_exc     (out_seg_exc)
   );

endmodule

// File: filelist.f
+incdir+.
ag_pkg.sv
ag_rf_if.sv
ag_dep_if.sv
register_file.sv
reg_dependency_check.sv
segment_limit_check.sv
address_generation.sv
ag_top.sv
tb_ag_top.sv

// File: reg_dependency_check.sv
`timescale 1ns/1ps

module reg_dependency_check (
   input  logic        v,
   ag_dep_if.check     dep,

   input  logic [2:0]  ex_drid,
   input  logic        v_ex_ld_gpr,
   input  logic        v_ex_ld_seg,
   input  logic [2:0]  me_drid,
   input  logic        v_me_ld_gpr,
   input  logic        v_me_ld_seg,

   output logic        stall
);

   logic lat_hit, ex_hit, me_hit;

   function automatic logic src_hit(input logic       need,
                                    input logic [2:0] src,
                                    input logic [2:0] dst,
                                    input logic       dst_v);
      return need && dst_v && (src == dst);
   endfunction

   // Own output latch
   assign lat_hit = src_hit(dep.need1,    dep.src1,    dep.lat_drid, dep.lat_ld_gpr)
                 || src_hit(dep.need2,    dep.src2,    dep.lat_drid, dep.lat_ld_gpr)
                 || src_hit(dep.need_idx, dep.src_idx, dep.lat_drid, dep.lat_ld_gpr)
                 || src_hit(dep.need_seg, dep.src_seg, dep.lat_drid, dep.lat_ld_seg);

   // EX stage
   assign ex_hit = src_hit(dep.need1,    dep.src1,    ex_drid, v_ex_ld_gpr)
                || src_hit(dep.need2,    dep.src2,    ex_drid, v_ex_ld_gpr)
                || src_hit(dep.need_idx, dep.src_idx, ex_drid, v_ex_ld_gpr)
                || src_hit(dep.need_seg, dep.src_seg, ex_drid, v_ex_ld_seg);

   // ME stage
   assign me_hit = src_hit(dep.need1,    dep.src1,    me_drid, v_me_ld_gpr)
                || src_hit(dep.need2,    dep.src2,    me_drid, v_me_ld_gpr)
                || src_hit(dep.need_idx, dep.src_idx, me_drid, v_me_ld_gpr)
                || src_hit(dep.need_seg, dep.src_seg, me_drid, v_me_ld_seg);

   // Nothing to hold back when decode has no instruction
   assign stall = v && (lat_hit || ex_hit || me_hit);

endmodule

// File: register_file.sv
`timescale 1ns/1ps
`include "ag_consts.svh"

module register_file (
   input  logic             clk,
   input  logic             rst_n,

   ag_rf_if.regs            rf,

   // General register write port
   input  logic             wb_gpr_we,
   input  ag_pkg::gpr_id_t  wb_gpr_id,
   input  logic [31:0]      wb_gpr_data,

   // Segment register write port
   input  logic             wb_seg_we,
   input  ag_pkg::seg_id_t  wb_seg_id,
   input  logic [15:0]      wb_seg_data
);

   logic [31:0] gpr [`AG_NUM_GPR];
   logic [15:0] seg [`AG_NUM_SEG];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `AG_NUM_GPR; i++) begin
            gpr[i] <= '0;
         end
      end else if (wb_gpr_we) begin
         gpr[wb_gpr_id] <= wb_gpr_data;
      end
   end

   // Selector IDs 6 and 7 have no register behind them
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `AG_NUM_SEG; i++) begin
            seg[i] <= '0;
         end
      end else if (wb_seg_we && (wb_seg_id < `AG_NUM_SEG)) begin
         seg[wb_seg_id] <= wb_seg_data;
      end
   end

   // Three general read ports: base, source 2 / ESP, SIB index
   assign rf.gpr_data_a   = gpr[rf.gpr_rd_a];
   assign rf.gpr_data_b   = gpr[rf.gpr_rd_b];
   assign rf.gpr_data_idx = gpr[rf.gpr_rd_idx];

   // Two segment read ports: operand segment and SS
   assign rf.seg_data_a = (rf.seg_rd_a < `AG_NUM_SEG) ? seg[rf.seg_rd_a] : 16'h0000;
   assign rf.seg_data_b = (rf.seg_rd_b < `AG_NUM_SEG) ? seg[rf.seg_rd_b] : 16'h0000;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module tb_ag_top \
   -f filelist.f \
   -o tb_ag_top

./obj_dir/tb_ag_top | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

// File: segment_limit_check.sv
`timescale 1ns/1ps
`include "ag_consts.svh"

module segment_limit_check (
   input  logic            v,
   input  ag_pkg::ag_op_e  op,
   input  ag_pkg::seg_id_t seg1,
   input  ag_pkg::size_e   data_size,
   input  logic [31:0]     offset,
   output logic            exc
);
   import ag_pkg::*;

   logic [31:0] limit;
   logic [1:0]  size_m1;
   logic [32:0] end_offset;

   always_comb begin
      case (seg1)
         3'd0:    limit = `AG_SEG_LIMIT0;
         3'd1:    limit = `AG_SEG_LIMIT1;
         3'd2:    limit = `AG_SEG_LIMIT2;
         3'd3:    limit = `AG_SEG_LIMIT3;
         3'd4:    limit = `AG_SEG_LIMIT4;
         3'd5:    limit = `AG_SEG_LIMIT5;
         default: limit = 32'h0;
      endcase
   end

   // Last byte touched by the access
   assign size_m1    = (data_size == sz32) ? 2'd3 : ((data_size == sz16) ? 2'd1 : 2'd0);
   // Carry bit keeps an access wrapping past 4G from slipping under the limit
   assign end_offset = {1'b0, offset} + {31'h0, size_m1};

   assign exc = v && ((op == op_load) || (op == op_store))
              && (end_offset > {1'b0, limit});

endmodule

// File: tb_ag_top.sv
`timescale 1ns/1ps
`include "ag_consts.svh"

module tb_ag_top;
   import ag_pkg::*;

   localparam int unsigned SEED        = 32'hac362876;
   localparam int          CYCLE_LIMIT = 4000;
   localparam int          RAND_OPS    = 880;

   logic        clk;
   logic        rst_n;

   logic        v;
   ag_op_e      op;
   gpr_id_t     sr1, sr2, sib_i;
   logic [1:0]  sib_s;
   logic        sib_en, disp_en, base_en;
   seg_id_t     seg1;
   size_e       data_size;
   logic [31:0] disp32, imm32, eip;
   logic [3:0]  exc_code;

   logic        wb_gpr_we;
   gpr_id_t     wb_gpr_id;
   logic [31:0] wb_gpr_data;
   logic        wb_seg_we;
   seg_id_t     wb_seg_id;
   logic [15:0] wb_seg_data;

   logic [2:0]  ex_drid, me_drid;
   logic        v_ex_ld_gpr, v_ex_ld_seg, v_me_ld_gpr, v_me_ld_seg;

   logic        stall, out_v, out_mem_rd, out_mem_wr, out_ld_gpr, out_seg_exc;
   ag_op_e      out_op;
   logic [31:0] out_a, out_b, out_neip, out_mem_rd_addr, out_mem_wr_addr;
   gpr_id_t     out_drid;

   // Reference register contents
   logic [31:0] gpr_m [`AG_NUM_GPR];
   logic [15:0] seg_m [`AG_NUM_SEG];

   // Prediction for the inputs driven this cycle
   logic        exp_stall, exp_acc, exp_ld_gpr, exp_mem_rd, exp_mem_wr, exp_exc;
   ag_op_e      exp_op;
   logic [31:0] exp_a, exp_b, exp_neip, exp_rd_addr, exp_wr_addr;
   gpr_id_t     exp_drid;

   // Prediction moved into the latch, compared one edge later
   logic        chk_v, chk_ld_gpr, chk_mem_rd, chk_mem_wr, chk_exc;
   ag_op_e      chk_op;
   logic [31:0] chk_a, chk_b, chk_neip, chk_rd_addr, chk_wr_addr;
   gpr_id_t     chk_drid;

   int err_cnt;
   int err_mark;
   int test_cnt;
   int cycle_cnt;

   ag_top UUT (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         chk_v      <= 1'b0;
         chk_ld_gpr <= 1'b0;
         chk_mem_rd <= 1'b0;
         chk_mem_wr <= 1'b0;
         chk_exc    <= 1'b0;
      end else begin
         chk_v      <= exp_acc;
         chk_ld_gpr <= exp_acc && exp_ld_gpr;
         chk_mem_rd <= exp_acc && exp_mem_rd;
         chk_mem_wr <= exp_acc && exp_mem_wr;
         chk_exc    <= exp_acc && exp_exc;
      end
   end

   always_ff @(posedge clk) begin
      chk_op      <= exp_op;
      chk_a       <= exp_a;
      chk_b       <= exp_b;
      chk_neip    <= exp_neip;
      chk_rd_addr <= exp_rd_addr;
      chk_wr_addr <= exp_wr_addr;
      chk_drid    <= exp_drid;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timeout: the run reached %0d cycles without finishing", CYCLE_LIMIT);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      err_cnt++;
      $display("CHECK FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp);
   endtask

   // Stall is combinational, the rest shows up one edge after acceptance
   a_stall: assert property (@(posedge clk) disable iff (!rst_n) stall == exp_stall)
      else report_mismatch("stall", 32'($sampled(stall)), 32'($sampled(exp_stall)));
   a_out_v: assert property (@(posedge clk) disable iff (!rst_n) out_v == chk_v)
      else report_mismatch("out_v", 32'($sampled(out_v)), 32'($sampled(chk_v)));
   a_ld_gpr: assert property (@(posedge clk) disable iff (!rst_n) out_ld_gpr == chk_ld_gpr)
      else report_mismatch("out_ld_gpr", 32'($sampled(out_ld_gpr)), 32'($sampled(chk_ld_gpr)));
   a_mem_rd: assert property (@(posedge clk) disable iff (!rst_n) out_mem_rd == chk_mem_rd)
      else report_mismatch("out_mem_rd", 32'($sampled(out_mem_rd)), 32'($sampled(chk_mem_rd)));
   a_mem_wr: assert property (@(posedge clk) disable iff (!rst_n) out_mem_wr == chk_mem_wr)
      else report_mismatch("out_mem_wr", 32'($sampled(out_mem_wr)), 32'($sampled(chk_mem_wr)));
   a_seg_exc: assert property (@(posedge clk) disable iff (!rst_n) out_seg_exc == chk_exc)
      else report_mismatch("out_seg_exc", 32'($sampled(out_seg_exc)), 32'($sampled(chk_exc)));
   a_op: assert property (@(posedge clk) disable iff (!rst_n) chk_v |-> out_op == chk_op)
      else report_mismatch("out_op", 32'($sampled(out_op)), 32'($sampled(chk_op)));
   a_a: assert property (@(posedge clk) disable iff (!rst_n) chk_v |-> out_a == chk_a)
      else report_mismatch("out_a", $sampled(out_a), $sampled(chk_a));
   a_b: assert property (@(posedge clk) disable iff (!rst_n) chk_v |-> out_b == chk_b)
      else report_mismatch("out_b", $sampled(out_b), $sampled(chk_b));
   a_neip: assert property (@(posedge clk) disable iff (!rst_n) chk_v |-> out_neip == chk_neip)
      else report_mismatch("out_neip", $sampled(out_neip), $sampled(chk_neip));
   a_rd_addr: assert property (@(posedge clk) disable iff (!rst_n)
                               chk_v |-> out_mem_rd_addr == chk_rd_addr)
      else report_mismatch("out_mem_rd_addr", $sampled(out_mem_rd_addr), $sampled(chk_rd_addr));
   a_wr_addr: assert property (@(posedge clk) disable iff (!rst_n)
                               chk_v |-> out_mem_wr_addr == chk_wr_addr)
      else report_mismatch("out_mem_wr_addr", $sampled(out_mem_wr_addr), $sampled(chk_wr_addr));
   a_drid: assert property (@(posedge clk) disable iff (!rst_n) chk_v |-> out_drid == chk_drid)
      else report_mismatch("out_drid", 32'($sampled(out_drid)), 32'($sampled(chk_drid)));

   function automatic logic [31:0] seg_limit(input seg_id_t s);
      case (s)
         3'd0:    return `AG_SEG_LIMIT0;
         3'd1:    return `AG_SEG_LIMIT1;
         3'd2:    return `AG_SEG_LIMIT2;
         3'd3:    return `AG_SEG_LIMIT3;
         3'd4:    return `AG_SEG_LIMIT4;
         3'd5:    return `AG_SEG_LIMIT5;
         default: return 32'h0;
      endcase
   endfunction

   function automatic int unsigned size_bytes(input size_e sz);
      return (sz == sz32) ? 4 : ((sz == sz16) ? 2 : 1);
   endfunction

   // Pending writers of a general register: own latch, EX, ME
   function automatic logic gpr_busy(input gpr_id_t r);
      return (chk_ld_gpr && chk_drid == r) || (v_ex_ld_gpr && ex_drid == r)
          || (v_me_ld_gpr && me_drid == r);
   endfunction

   function automatic logic seg_busy(input seg_id_t s);
      return (v_ex_ld_seg && ex_drid == s) || (v_me_ld_seg && me_drid == s);
   endfunction

   task automatic predict();
      logic [31:0] offset, seg_addr, new_sp, stack_addr, int_addr;
      logic [32:0] last_byte;
      logic        is_ld, is_st, is_push, is_alu, need_seg;
      seg_id_t     src_seg;
      is_ld    = (op == op_load);
      is_st    = (op == op_store);
      is_push  = (op == op_push);
      is_alu   = (op == op_alu_rr) || (op == op_alu_ri);
      offset   = (base_en ? gpr_m[sr1] : 32'h0) + (disp_en ? disp32 : 32'h0)
               + (sib_en ? (gpr_m[sib_i] << sib_s) : 32'h0);
      seg_addr = {seg_m[seg1], 16'h0000} + offset;
      new_sp     = gpr_m[sr2] - ((data_size == sz16) ? 32'd2 : 32'd4);
      stack_addr = {seg_m[`AG_SS_ID], 16'h0000} + new_sp;
      int_addr   = `AG_IDTR_BASE + 32'(exc_code) * 32'd8;
      last_byte  = {1'b0, offset} + 33'(size_bytes(data_size)) - 33'd1;
      exp_exc    = (is_ld || is_st) && (last_byte > {1'b0, seg_limit(seg1)});
      need_seg   = is_ld || is_st || is_push;
      src_seg    = is_push ? seg_id_t'(`AG_SS_ID) : seg1;
      exp_stall  = v && (((base_en || is_alu || is_push) && gpr_busy(sr1))
                      || (((op == op_alu_rr) || is_st || is_push) && gpr_busy(sr2))
                      || (sib_en && gpr_busy(sib_i))
                      || (need_seg && seg_busy(src_seg)));
      exp_acc     = v && !exp_stall;
      exp_mem_rd  = (is_ld || (op == op_int)) && !exp_exc;
      exp_mem_wr  = (is_st || is_push) && !exp_exc;
      exp_ld_gpr  = is_alu || is_ld || is_push;
      exp_drid    = is_push ? sr2 : sr1;
      exp_op      = op;
      exp_a       = gpr_m[sr1];
      exp_b       = (op == op_alu_ri) ? imm32 : gpr_m[sr2];
      exp_neip    = (op == op_jmp_rel) ? (eip + disp32) : eip;
      exp_rd_addr = (op == op_int) ? int_addr : seg_addr;
      exp_wr_addr = is_push ? stack_addr : seg_addr;
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #2;
      v           = 1'b0;
      wb_gpr_we   = 1'b0;
      wb_seg_we   = 1'b0;
      v_ex_ld_gpr = 1'b0;
      v_ex_ld_seg = 1'b0;
      v_me_ld_gpr = 1'b0;
      v_me_ld_seg = 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         next_cycle();
         predict();
      end
   endtask

   task automatic set_instr(input ag_op_e o, input gpr_id_t r1, input gpr_id_t r2,
                            input seg_id_t s, input size_e sz);
      v         = 1'b1;
      op        = o;
      sr1       = r1;
      sr2       = r2;
      seg1      = s;
      data_size = sz;
      base_en   = 1'b0;
      disp_en   = 1'b0;
      sib_en    = 1'b0;
      sib_i     = '0;
      sib_s     = '0;
      disp32    = '0;
      imm32     = '0;
      eip       = '0;
      exc_code  = '0;
   endtask

   // The model takes the new value once the edge has written it
   task automatic write_gpr(input gpr_id_t id, input logic [31:0] data);
      next_cycle();
      wb_gpr_we   = 1'b1;
      wb_gpr_id   = id;
      wb_gpr_data = data;
      predict();
      gpr_m[id] = data;
   endtask

   task automatic write_seg(input seg_id_t id, input logic [15:0] data);
      next_cycle();
      wb_seg_we   = 1'b1;
      wb_seg_id   = id;
      wb_seg_data = data;
      predict();
      seg_m[id] = data;
   endtask

   task automatic finish_test(input string name);
      idle(2);
      test_cnt++;
      $display("%-14s done, %0d failed checks", name, err_cnt - err_mark);
      err_mark = err_cnt;
   endtask

   initial begin
      size_e sz;
      void'($urandom(SEED));
      err_cnt   = 0;
      err_mark  = 0;
      test_cnt  = 0;
      cycle_cnt = 0;
      rst_n     = 1'b0;
      set_instr(op_alu_rr, '0, '0, '0, sz32);
      v           = 1'b0;
      wb_gpr_we   = 1'b0;
      wb_gpr_id   = '0;
      wb_gpr_data = '0;
      wb_seg_we   = 1'b0;
      wb_seg_id   = '0;
      wb_seg_data = '0;
      ex_drid     = '0;
      me_drid     = '0;
      v_ex_ld_gpr = 1'b0;
      v_ex_ld_seg = 1'b0;
      v_me_ld_gpr = 1'b0;
      v_me_ld_seg = 1'b0;
      for (int i = 0; i < `AG_NUM_GPR; i++) gpr_m[i] = '0;
      for (int i = 0; i < `AG_NUM_SEG; i++) seg_m[i] = '0;
      predict();
      repeat (3) @(posedge clk);
      #2 rst_n = 1'b1;

      // Cleared registers read back through the operands
      next_cycle();
      set_instr(op_alu_rr, 3'd3, 3'd5, 3'd0, sz32);
      predict();
      finish_test("reset_state");

      for (int i = 0; i < `AG_NUM_GPR; i++) write_gpr(gpr_id_t'(i), $urandom & 32'h0000_0FFF);
      for (int i = 0; i < `AG_NUM_SEG; i++) write_seg(seg_id_t'(i), 16'($urandom));
      repeat (RAND_OPS) begin
         next_cycle();
         set_instr(($urandom & 1) ? op_load : op_store, gpr_id_t'($urandom),
                   gpr_id_t'($urandom), seg_id_t'($urandom % 6), size_e'(2'($urandom % 3)));
         base_en = 1'($urandom);
         disp_en = 1'($urandom);
         sib_en  = 1'($urandom);
         sib_i   = gpr_id_t'($urandom);
         sib_s   = 2'($urandom);
         disp32  = $urandom & 32'h0000_03FF;
         predict();
         idle(1);
      end
      finish_test("load_store");

      write_gpr(gpr_id_t'(4), 32'h0000_2000);
      write_seg(seg_id_t'(`AG_SS_ID), 16'h0030);
      for (int k = 0; k < 2; k++) begin
         next_cycle();
         set_instr(op_push, 3'd1, 3'd4, 3'd0, (k == 0) ? sz16 : sz32);
         predict();
         idle(1);
      end
      for (int c = 0; c < 16; c += 5) begin
         next_cycle();
         set_instr(op_int, 3'd0, 3'd0, 3'd0, sz32);
         exc_code = 4'(c);
         predict();
         idle(1);
      end
      next_cycle();
      set_instr(op_jmp_rel, 3'd0, 3'd0, 3'd0, sz32);
      eip    = $urandom;
      disp32 = $urandom;
      predict();
      next_cycle();
      set_instr(op_alu_ri, 3'd2, 3'd6, 3'd0, sz32);
      imm32 = $urandom;
      predict();
      finish_test("push_int_jmp");

      // EX writes the base register
      next_cycle();
      set_instr(op_alu_rr, 3'd1, 3'd2, 3'd0, sz32);
      v_ex_ld_gpr = 1'b1;
      ex_drid     = 3'd1;
      predict();
      idle(1);
      // ME writes the SIB index
      next_cycle();
      set_instr(op_load, 3'd0, 3'd0, 3'd3, sz32);
      sib_en      = 1'b1;
      sib_i       = 3'd6;
      v_me_ld_gpr = 1'b1;
      me_drid     = 3'd6;
      predict();
      idle(1);
      next_cycle();
      set_instr(op_store, 3'd0, 3'd5, 3'd3, sz16);
      v_ex_ld_seg = 1'b1;
      ex_drid     = 3'd3;
      predict();
      idle(1);
      next_cycle();
      set_instr(op_push, 3'd0, 3'd4, 3'd0, sz32);
      v_me_ld_seg = 1'b1;
      me_drid     = 3'(`AG_SS_ID);
      predict();
      idle(1);
      // Load into EBX followed at once by a reader of EBX
      next_cycle();
      set_instr(op_load, 3'd3, 3'd0, 3'd3, sz32);
      predict();
      next_cycle();
      set_instr(op_alu_rr, 3'd0, 3'd3, 3'd0, sz32);
      predict();
      idle(1);
      next_cycle();
      set_instr(op_alu_rr, 3'd1, 3'd2, 3'd0, sz32);
      v_ex_ld_gpr = 1'b1;
      ex_drid     = 3'd7;
      v_me_ld_gpr = 1'b1;
      me_drid     = 3'd5;
      predict();
      idle(1);
      // Matching IDs, but nobody is writing them
      next_cycle();
      set_instr(op_alu_rr, 3'd1, 3'd2, 3'd0, sz32);
      ex_drid     = 3'd1;
      me_drid     = 3'd2;
      v_ex_ld_seg = 1'b1;
      predict();
      idle(1);
      next_cycle();
      set_instr(op_alu_rr, 3'd1, 3'd2, 3'd0, sz32);
      v           = 1'b0;
      v_ex_ld_gpr = 1'b1;
      ex_drid     = 3'd1;
      predict();
      finish_test("dependency");

      // Last byte one below, at and one above each limit
      for (int s = 0; s < `AG_NUM_SEG; s++) begin
         for (int d = 0; d < 3; d++) begin
            for (int k = 0; k < 2; k++) begin
               next_cycle();
               sz = size_e'(2'((s + d) % 3));
               set_instr((k == 0) ? op_load : op_store, 3'd0, 3'd0, seg_id_t'(s), sz);
               disp_en = 1'b1;
               disp32  = seg_limit(seg_id_t'(s)) - 32'(size_bytes(sz)) + 32'(d);
               predict();
               idle(1);
            end
         end
      end
      finish_test("segment_limit");

      $display("tests run: %0d, failed checks: %0d", test_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
